/* hdl/rom_defs.svh */
// Region offsets and widths are fixed for one game layout; offsets are SDRAM word units
`ifndef ROM_DEFS_SVH
`define ROM_DEFS_SVH

// SDRAM read port
`define ROM_SDRAM_AW    22              // Word address width

// Client address widths
`define ROM_MAIN_AW     17              // Main CPU, byte address
`define ROM_SND_AW      15              // Sound CPU, byte address
`define ROM_CHAR_AW     13              // Character layer, half-word address
`define ROM_OBJ_AW      15              // Object layer, half-word address

// Client data widths
`define ROM_BYTE_DW     8
`define ROM_HALF_DW     16

// Region start of each client inside the SDRAM
`define ROM_MAIN_OFFSET 22'h00000
`define ROM_SND_OFFSET  22'h0A000
`define ROM_CHAR_OFFSET 22'h0E000
`define ROM_OBJ_OFFSET  22'h20000

// Cycles from reset or download release until ready, at least 1
`define ROM_READY_DELAY 4

`endif

/* hdl/rom_pkg.sv */
// Client order here sets the bit order of every req, ok, en and sel vector
package rom_pkg;

    // One SDRAM word, read as bytes by the CPUs and as halves by the layers
    typedef union packed {
        logic [3:0][7:0]  bytes;        // Byte 0 is bits 7:0
        logic [1:0][15:0] halves;       // Half 0 is bits 15:0
    } rom_word_u;

    // Bit position of each client in the one-hot vectors
    typedef enum logic [1:0] {
        cl_main = 2'd0,                 // Main CPU
        cl_snd  = 2'd1,                 // Sound CPU
        cl_char = 2'd2,                 // Character layer
        cl_obj  = 2'd3                  // Object layer
    } rom_client_e;

endpackage

/* hdl/rom_client.sv */
// DW must be 8 (AW >= 3) or 16 (AW >= 2); a single word is held, so any word change is a miss
`include "rom_defs.svh"

module rom_client #(
    parameter int AW = 17,                          // Address width in client units
    parameter int DW = 8                            // Data width, 8 or 16
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [AW-1:0]            addr,
    input  logic                     en,
    input  rom_pkg::rom_word_u       data_read,
    input  logic                     data_rdy,
    input  logic                     sel,
    input  logic                     flush,
    output logic                     req,
    output logic [`ROM_SDRAM_AW-1:0] word_addr,
    output logic [DW-1:0]            dout,
    output logic                     ok
);
    import rom_pkg::*;

    rom_word_u                held;                 // Last word fetched
    logic [`ROM_SDRAM_AW-1:0] tag;                  // Word address of held
    logic [`ROM_SDRAM_AW-1:0] req_tag;              // Word address sent at grant
    logic                     valid;
    logic                     hit;
    logic                     capture;

    // Address decode into word and lane
    generate
        if (DW == `ROM_BYTE_DW) begin : g_byte
            assign word_addr = {{(`ROM_SDRAM_AW - AW + 2){1'b0}}, addr[AW-1:2]};
            assign dout      = held.bytes[addr[1:0]];
        end else begin : g_half
            assign word_addr = {{(`ROM_SDRAM_AW - AW + 1){1'b0}}, addr[AW-1:1]};
            assign dout      = held.halves[addr[0]];
        end
    endgenerate

    assign hit     = valid && (tag == word_addr);
    assign ok      = en && hit;
    assign req     = en && !hit;                    // Held until the word comes back
    assign capture = data_rdy && sel;               // Our transfer finished

    // The arbiter samples word_addr on the edge that raises sel,
    // so tracking it while unselected gives the address in flight
    always_ff @(posedge clk) begin
        if (!sel) begin
            req_tag <= word_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            held <= data_read;
            tag  <= req_tag;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;                          // ROM contents may change
        end else if (capture) begin
            valid <= 1'b1;
        end
    end

endmodule

/* hdl/rom_arbiter.sv */
// One SDRAM transfer in flight at a time; waits on sdram_ack and data_rdy with no timeout
`include "rom_defs.svh"

module rom_arbiter (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     downloading,
    input  logic [3:0]               req,
    input  logic [`ROM_SDRAM_AW-1:0] main_waddr,
    input  logic [`ROM_SDRAM_AW-1:0] snd_waddr,
    input  logic [`ROM_SDRAM_AW-1:0] char_waddr,
    input  logic [`ROM_SDRAM_AW-1:0] obj_waddr,
    input  logic [3:0]               ok,
    input  logic [3:0]               en,
    input  logic                     sdram_ack,
    input  logic                     data_rdy,
    output logic [3:0]               sel,
    output logic                     sdram_req,
    output logic [`ROM_SDRAM_AW-1:0] sdram_addr,
    output logic                     refresh_en,
    output logic                     ready
);
    import rom_pkg::*;

    localparam logic [3:0] READY_LAST = 4'(`ROM_READY_DELAY - 1);

    logic [3:0]               valid_req;
    logic [3:0]               grant;
    logic [`ROM_SDRAM_AW-1:0] grant_addr;
    logic                     take;
    logic                     all_ok;
    logic [3:0]               ready_cnt;

    // A client already being served must not be picked twice
    assign valid_req = req & ~sel;

    // New grant when idle or when the current word arrives
    assign take = !(|sel) || data_rdy;

    // Disabled clients do not hold refresh back
    assign all_ok = &(ok | ~en);

    // Fixed priority: obj, char, main, snd
    always_comb begin
        grant      = '0;
        grant_addr = '0;
        if (valid_req[cl_obj]) begin
            grant[cl_obj] = 1'b1;
            grant_addr    = `ROM_OBJ_OFFSET + obj_waddr;
        end else if (valid_req[cl_char]) begin
            grant[cl_char] = 1'b1;
            grant_addr     = `ROM_CHAR_OFFSET + char_waddr;
        end else if (valid_req[cl_main]) begin
            grant[cl_main] = 1'b1;
            grant_addr     = `ROM_MAIN_OFFSET + main_waddr;
        end else if (valid_req[cl_snd]) begin
            grant[cl_snd] = 1'b1;
            grant_addr    = `ROM_SND_OFFSET + snd_waddr;
        end
    end

    // SDRAM handshake and client select
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sel       <= '0;
            sdram_req <= 1'b0;
        end else if (downloading) begin
            sel       <= '0;                        // SDRAM belongs to the loader
            sdram_req <= 1'b0;
        end else begin
            if (sdram_ack) begin
                sdram_req <= 1'b0;
            end
            if (take) begin
                sel       <= grant;
                sdram_req <= |grant;
            end
        end
    end

    // Address stays put for the whole transfer
    always_ff @(posedge clk) begin
        if (!downloading && take && |grant) begin
            sdram_addr <= grant_addr;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            refresh_en <= 1'b0;
        end else if (downloading) begin
            refresh_en <= 1'b0;
        end else begin
            refresh_en <= all_ok;
        end
    end

    // Ready timer, restarted by reset and by each download
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_cnt <= '0;
            ready     <= 1'b0;
        end else if (downloading) begin
            ready_cnt <= '0;
            ready     <= 1'b0;
        end else if (!ready) begin
            if (ready_cnt == READY_LAST) begin
                ready <= 1'b1;
            end else begin
                ready_cnt <= ready_cnt + 4'd1;
            end
        end
    end

endmodule

/* hdl/rom_top.sv */
// Char layer only fetches while lvbl is high and obj always fetches; no SDRAM controller inside
`include "rom_defs.svh"

module rom_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     lvbl,
    input  logic                     downloading,
    input  logic                     main_cs,
    input  logic                     snd_cs,
    input  logic [`ROM_MAIN_AW-1:0]  main_addr,
    input  logic [`ROM_SND_AW-1:0]   snd_addr,
    input  logic [`ROM_CHAR_AW-1:0]  char_addr,
    input  logic [`ROM_OBJ_AW-1:0]   obj_addr,
    input  logic                     sdram_ack,
    input  logic                     data_rdy,
    input  rom_pkg::rom_word_u       data_read,
    output logic [`ROM_BYTE_DW-1:0]  main_dout,
    output logic [`ROM_BYTE_DW-1:0]  snd_dout,
    output logic [`ROM_HALF_DW-1:0]  char_dout,
    output logic [`ROM_HALF_DW-1:0]  obj_dout,
    output logic                     main_ok,
    output logic                     snd_ok,
    output logic                     sdram_req,
    output logic [`ROM_SDRAM_AW-1:0] sdram_addr,
    output logic                     refresh_en,
    output logic                     ready
);
    import rom_pkg::*;

    logic [3:0]               sel;
    logic                     main_req;
    logic                     snd_req;
    logic                     char_req;
    logic                     obj_req;
    logic                     char_ok;
    logic                     obj_ok;
    logic [`ROM_SDRAM_AW-1:0] main_waddr;
    logic [`ROM_SDRAM_AW-1:0] snd_waddr;
    logic [`ROM_SDRAM_AW-1:0] char_waddr;
    logic [`ROM_SDRAM_AW-1:0] obj_waddr;

    rom_client #(.AW(`ROM_MAIN_AW), .DW(`ROM_BYTE_DW)) u_main (
        .clk       (clk),
        .arst_n    (arst_n),
        .addr      (main_addr),
        .en        (main_cs),
        .data_read (data_read),
        .data_rdy  (data_rdy),
        .sel       (sel[cl_main]),
        .flush     (downloading),
        .req       (main_req),
        .word_addr (main_waddr),
        .dout      (main_dout),
        .ok        (main_ok)
    );

    rom_client #(.AW(`ROM_SND_AW), .DW(`ROM_BYTE_DW)) u_snd (
        .clk       (clk),
        .arst_n    (arst_n),
        .addr      (snd_addr),
        .en        (snd_cs),
        .data_read (data_read),
        .data_rdy  (data_rdy),
        .sel       (sel[cl_snd]),
        .flush     (downloading),
        .req       (snd_req),
        .word_addr (snd_waddr),
        .dout      (snd_dout),
        .ok        (snd_ok)
    );

    rom_client #(.AW(`ROM_CHAR_AW), .DW(`ROM_HALF_DW)) u_char (
        .clk       (clk),
        .arst_n    (arst_n),
        .addr      (char_addr),
        .en        (lvbl),                          // Active display only
        .data_read (data_read),
        .data_rdy  (data_rdy),
        .sel       (sel[cl_char]),
        .flush     (downloading),
        .req       (char_req),
        .word_addr (char_waddr),
        .dout      (char_dout),
        .ok        (char_ok)
    );

    rom_client #(.AW(`ROM_OBJ_AW), .DW(`ROM_HALF_DW)) u_obj (
        .clk       (clk),
        .arst_n    (arst_n),
        .addr      (obj_addr),
        .en        (1'b1),
        .data_read (data_read),
        .data_rdy  (data_rdy),
        .sel       (sel[cl_obj]),
        .flush     (downloading),
        .req       (obj_req),
        .word_addr (obj_waddr),
        .dout      (obj_dout),
        .ok        (obj_ok)
    );

    // Vector bit order follows rom_client_e
    rom_arbiter u_arb (
        .clk         (clk),
        .arst_n      (arst_n),
        .downloading (downloading),
        .req         ({obj_req, char_req, snd_req, main_req}),
        .main_waddr  (main_waddr),
        .snd_waddr   (snd_waddr),
        .char_waddr  (char_waddr),
        .obj_waddr   (obj_waddr),
        .ok          ({obj_ok, char_ok, snd_ok, main_ok}),
        .en          ({1'b1, lvbl, snd_cs, main_cs}),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .sel         (sel),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .refresh_en  (refresh_en),
        .ready       (ready)
    );

endmodule

/* verif/sdram_model.sv */
// Read-only SDRAM stand-in: one request at a time, word at A is {10'h2A5, A}, abort drops it
module sdram_model (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               abort,
    input  logic               sdram_req,
    input  logic [21:0]        sdram_addr,
    output logic               sdram_ack,
    output logic               data_rdy,
    output rom_pkg::rom_word_u data_read
);
    timeunit 1ns;
    timeprecision 1ps;

    integer      seed = 32'h8b6;
    logic [1:0]  phase;                             // 0 idle, 1 ack wait, 2 data wait
    logic [2:0]  cnt;
    logic [21:0] addr_q;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase     <= 2'd0;
            cnt       <= 3'd0;
            addr_q    <= '0;
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
        end else begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            if (abort) begin
                phase <= 2'd0;                      // Loader owns the SDRAM
            end else begin
                case (phase)
                    2'd0: if (sdram_req) begin
                        cnt   <= 3'(1 + $unsigned($random(seed)) % 3);
                        phase <= 2'd1;
                    end
                    2'd1: if (cnt == 3'd1) begin
                        sdram_ack <= 1'b1;
                        addr_q    <= sdram_addr;
                        cnt       <= 3'(2 + $unsigned($random(seed)) % 5);
                        phase     <= 2'd2;
                    end else begin
                        cnt <= cnt - 3'd1;
                    end
                    default: if (cnt == 3'd1) begin
                        data_rdy  <= 1'b1;
                        data_read <= {10'h2A5, addr_q};
                        phase     <= 2'd0;
                    end else begin
                        cnt <= cnt - 3'd1;
                    end
                endcase
            end
        end
    end

endmodule

/* verif/rom_assertions.sv */
// Bound into rom_top; expects the SDRAM pattern {10'h2A5, A} and sets fail on any violation
`include "rom_defs.svh"

module rom_assertions (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     downloading,
    input logic                     lvbl,
    input logic                     main_cs,
    input logic                     snd_cs,
    input logic [`ROM_MAIN_AW-1:0]  main_addr,
    input logic [`ROM_SND_AW-1:0]   snd_addr,
    input logic [`ROM_CHAR_AW-1:0]  char_addr,
    input logic [`ROM_OBJ_AW-1:0]   obj_addr,
    input logic [`ROM_BYTE_DW-1:0]  main_dout,
    input logic [`ROM_BYTE_DW-1:0]  snd_dout,
    input logic [`ROM_HALF_DW-1:0]  char_dout,
    input logic [`ROM_HALF_DW-1:0]  obj_dout,
    input logic                     main_ok,
    input logic                     snd_ok,
    input logic                     char_ok,
    input logic                     obj_ok,
    input logic                     main_req,
    input logic                     snd_req,
    input logic                     char_req,
    input logic                     obj_req,
    input logic [3:0]               sel,
    input logic                     sdram_req,
    input logic                     sdram_ack,
    input logic                     data_rdy,
    input logic [`ROM_SDRAM_AW-1:0] sdram_addr,
    input logic                     refresh_en,
    input logic                     ready
);
    timeunit 1ns;
    timeprecision 1ps;

    logic                     fail = 1'b0;
    logic [31:0]              main_word, snd_word, char_word, obj_word;
    logic [7:0]               exp_main, exp_snd;
    logic [15:0]              exp_char, exp_obj;
    logic [3:0]               pend;                 // Bits ordered main, snd, char, obj
    logic                     take;
    logic                     all_ok;
    logic [`ROM_SDRAM_AW-1:0] exp_grant, grant_q;

    // Expected SDRAM contents at a word address
    function automatic logic [31:0] word_at(input logic [`ROM_SDRAM_AW-1:0] a);
        return {10'h2A5, a};
    endfunction

    assign main_word = word_at(`ROM_MAIN_OFFSET + 22'(main_addr >> 2));
    assign snd_word  = word_at(`ROM_SND_OFFSET + 22'(snd_addr >> 2));
    assign char_word = word_at(`ROM_CHAR_OFFSET + 22'(char_addr >> 1));
    assign obj_word  = word_at(`ROM_OBJ_OFFSET + 22'(obj_addr >> 1));
    assign exp_main  = main_word[8*main_addr[1:0] +: 8];
    assign exp_snd   = snd_word[8*snd_addr[1:0] +: 8];
    assign exp_char  = char_word[16*char_addr[0] +: 16];
    assign exp_obj   = obj_word[16*obj_addr[0] +: 16];

    assign pend   = {obj_req, char_req, snd_req, main_req} & ~sel;
    assign take   = (sel == 4'd0) || data_rdy;
    assign all_ok = (main_ok || !main_cs) && (snd_ok || !snd_cs) && (char_ok || !lvbl) && obj_ok;

    // Highest pending requester wins in the order obj, char, main, snd
    assign exp_grant = pend[3] ? `ROM_OBJ_OFFSET + 22'(obj_addr >> 1) :
                       pend[2] ? `ROM_CHAR_OFFSET + 22'(char_addr >> 1) :
                       pend[0] ? `ROM_MAIN_OFFSET + 22'(main_addr >> 2) :
                                 `ROM_SND_OFFSET + 22'(snd_addr >> 2);

    always_ff @(posedge clk) begin
        grant_q <= exp_grant;
    end

    a_main_data: assert property (@(posedge clk) disable iff (!arst_n)
        main_ok && main_cs |-> main_dout == exp_main)
        else begin
            fail = 1'b1;
            $error("ERROR %0t main_dout expected %h actual %h", $time,
                   $sampled(exp_main), $sampled(main_dout));
        end

    a_snd_data: assert property (@(posedge clk) disable iff (!arst_n)
        snd_ok && snd_cs |-> snd_dout == exp_snd)
        else begin
            fail = 1'b1;
            $error("ERROR %0t snd_dout expected %h actual %h", $time,
                   $sampled(exp_snd), $sampled(snd_dout));
        end

    a_char_data: assert property (@(posedge clk) disable iff (!arst_n)
        char_ok |-> char_dout == exp_char)
        else begin
            fail = 1'b1;
            $error("ERROR %0t char_dout expected %h actual %h", $time,
                   $sampled(exp_char), $sampled(char_dout));
        end

    a_obj_data: assert property (@(posedge clk) disable iff (!arst_n)
        obj_ok |-> obj_dout == exp_obj)
        else begin
            fail = 1'b1;
            $error("ERROR %0t obj_dout expected %h actual %h", $time,
                   $sampled(exp_obj), $sampled(obj_dout));
        end

    // A CPU word that comes back makes ok rise on the next cycle
    a_main_ok: assert property (@(posedge clk) disable iff (!arst_n || downloading)
        main_cs && data_rdy && sel[0] |=> main_ok)
        else begin
            fail = 1'b1;
            $error("ERROR %0t main_ok expected 1 actual %b", $time, $sampled(main_ok));
        end

    a_snd_ok: assert property (@(posedge clk) disable iff (!arst_n || downloading)
        snd_cs && data_rdy && sel[1] |=> snd_ok)
        else begin
            fail = 1'b1;
            $error("ERROR %0t snd_ok expected 1 actual %b", $time, $sampled(snd_ok));
        end

    // Request is held until the SDRAM takes it
    a_req_hold: assert property (@(posedge clk) disable iff (!arst_n || downloading)
        sdram_req && !sdram_ack |=> sdram_req)
        else begin
            fail = 1'b1;
            $error("ERROR %0t sdram_req expected 1 actual %b", $time, $sampled(sdram_req));
        end

    a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n || downloading)
        (sel != 4'd0) && !data_rdy |=> $stable(sdram_addr))
        else begin
            fail = 1'b1;
            $error("ERROR %0t sdram_addr changed mid transfer, actual %h", $time,
                   $sampled(sdram_addr));
        end

    a_priority: assert property (@(posedge clk) disable iff (!arst_n || downloading)
        take && (pend != 4'd0) |=> sdram_addr == grant_q)
        else begin
            fail = 1'b1;
            $error("ERROR %0t sdram_addr expected %h actual %h", $time,
                   $sampled(grant_q), $sampled(sdram_addr));
        end

    a_refresh_on: assert property (@(posedge clk) disable iff (!arst_n)
        all_ok && !downloading |=> refresh_en)
        else begin
            fail = 1'b1;
            $error("ERROR %0t refresh_en expected 1 actual %b", $time, $sampled(refresh_en));
        end

    a_refresh_off: assert property (@(posedge clk) disable iff (!arst_n)
        !(all_ok && !downloading) |=> !refresh_en)
        else begin
            fail = 1'b1;
            $error("ERROR %0t refresh_en expected 0 actual %b", $time, $sampled(refresh_en));
        end

    a_ready_delay: assert property (@(posedge clk) disable iff (!arst_n || downloading)
        $rose(arst_n) || $fell(downloading) |-> !ready [*`ROM_READY_DELAY] ##1 ready)
        else begin
            fail = 1'b1;
            $error("ERROR %0t ready wrong after release, actual %b", $time, $sampled(ready));
        end

    a_no_req_dl: assert property (@(posedge clk) disable iff (!arst_n)
        downloading |=> !sdram_req)
        else begin
            fail = 1'b1;
            $error("ERROR %0t sdram_req expected 0 actual %b", $time, $sampled(sdram_req));
        end

endmodule

/* verif/tb_rom.sv */
// Runs 400 SDRAM transfers of random client traffic with one download pulse; checks are bound
`include "rom_defs.svh"

module tb_rom;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TRANS   = 400;
    localparam int CYCLE_LIMIT = NUM_TRANS * 12 + 500;

    logic                     clk;
    logic                     arst_n;
    logic                     lvbl;
    logic                     downloading;
    logic                     main_cs;
    logic                     snd_cs;
    logic [`ROM_MAIN_AW-1:0]  main_addr;
    logic [`ROM_SND_AW-1:0]   snd_addr;
    logic [`ROM_CHAR_AW-1:0]  char_addr;
    logic [`ROM_OBJ_AW-1:0]   obj_addr;
    logic                     sdram_ack;
    logic                     data_rdy;
    rom_pkg::rom_word_u       data_read;
    logic [`ROM_BYTE_DW-1:0]  main_dout, snd_dout;
    logic [`ROM_HALF_DW-1:0]  char_dout, obj_dout;
    logic                     main_ok, snd_ok;
    logic                     sdram_req;
    logic [`ROM_SDRAM_AW-1:0] sdram_addr;
    logic                     refresh_en;
    logic                     ready;

    integer seed = 32'h8b6;
    int     done_count = 0;                         // Completed SDRAM transfers
    int     cycles = 0;
    int     char_hold, obj_hold, dl_cnt;
    logic   dl_done;

    bind rom_top rom_assertions u_chk (.*);

    rom_top u_rom_top (.*);

    sdram_model u_sdram (
        .clk        (clk),
        .arst_n     (arst_n),
        .abort      (downloading),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .sdram_ack  (sdram_ack),
        .data_rdy   (data_rdy),
        .data_read  (data_read)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (data_rdy) begin
            done_count <= done_count + 1;
        end
    end

    // Random traffic, CPU addresses held until served
    always @(posedge clk) begin : drive_traffic
        logic [31:0] r1, r2, r3, r4;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        r4 = $random(seed);
        if (arst_n) begin
            if (!main_cs || main_ok) begin
                main_cs   <= r1[0] | r1[1];
                main_addr <= r1[2] ? main_addr + 1'b1 : r1[31:15];
            end
            if (!snd_cs || snd_ok) begin
                snd_cs   <= r2[0] | r2[1];
                snd_addr <= r2[2] ? snd_addr + 1'b1 : r2[31:17];
            end
            if (char_hold == 0) begin
                char_addr <= r3[4] ? char_addr + 1'b1 : r3[31:19];
                char_hold <= 4 + r3[7:5];
                if (r3[2:0] == 3'd0) begin
                    lvbl <= ~lvbl;
                end
            end else begin
                char_hold <= char_hold - 1;
            end
            if (obj_hold == 0) begin
                obj_addr <= r4[4] ? obj_addr + 1'b1 : r4[31:17];
                obj_hold <= 4 + r4[7:5];
            end else begin
                obj_hold <= obj_hold - 1;
            end
            // One download pulse in mid run
            if (dl_cnt != 0) begin
                dl_cnt <= dl_cnt - 1;
                if (dl_cnt == 1) begin
                    downloading <= 1'b0;
                end
            end else if (!dl_done && done_count >= NUM_TRANS / 2) begin
                downloading <= 1'b1;
                dl_cnt      <= 6;
                dl_done     <= 1'b1;
            end
        end
    end

    initial begin
        arst_n      = 1'b0;
        lvbl        = 1'b1;
        downloading = 1'b0;
        main_cs     = 1'b0;
        snd_cs      = 1'b0;
        main_addr   = '0;
        snd_addr    = '0;
        char_addr   = '0;
        obj_addr    = '0;
        char_hold   = 0;
        obj_hold    = 0;
        dl_cnt      = 0;
        dl_done     = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        while (done_count < NUM_TRANS && !u_rom_top.u_chk.fail && cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        @(negedge clk);                             // Checks of the last edge have finished
        if (u_rom_top.u_chk.fail || cycles >= CYCLE_LIMIT) begin
            $display("Regression failed");
            if (cycles >= CYCLE_LIMIT) begin
                $fatal(1, "Timeout after %0d cycles with %0d of %0d transfers done",
                       cycles, done_count, NUM_TRANS);
            end else begin
                $fatal(1, "An assertion check failed");
            end
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

/* sources.f */
+incdir+hdl
hdl/rom_pkg.sv
hdl/rom_client.sv
hdl/rom_arbiter.sv
hdl/rom_top.sv
verif/sdram_model.sv
verif/rom_assertions.sv
verif/tb_rom.sv
